// ==== hw/zynq_bridge_pkg.sv ====
package zynq_bridge_pkg;

   localparam int unsigned WORD_W        = 32;
   localparam int unsigned HOST_ADDR_W   = 30;
   localparam int unsigned CSR_IDX_W     = 4;
   localparam int unsigned REGION_W      = 7;
   localparam int unsigned PROFILE_WORDS = 4;

   typedef logic [WORD_W-1:0]               word_t;
   typedef logic [HOST_ADDR_W-1:0]          host_addr_t;
   typedef logic [31:0]                     bp_addr_t;
   typedef logic [CSR_IDX_W-1:0]            csr_idx_t;
   typedef logic [REGION_W-1:0]             region_idx_t;
   typedef logic [PROFILE_WORDS*WORD_W-1:0] profile_t;

   // the accelerator sees its DRAM starting here
   localparam word_t BP_DRAM_BASE = 32'h8000_0000;

   // shell register map, indexed by host address bits 5 to 2
   localparam csr_idx_t CSR_RUN        = 4'd0;
   localparam csr_idx_t CSR_DRAM_VALID = 4'd1;
   localparam csr_idx_t CSR_DRAM_BASE  = 4'd2;
   // four read-only profiler words follow, lowest bits first
   localparam csr_idx_t CSR_PROFILE0   = 4'd4;

   typedef enum logic {
      WIN_SHELL,
      WIN_ACCEL
   } window_e;

   typedef enum logic [2:0] {
      OP_CSR_RD,
      OP_CSR_WR,
      OP_MEM_RD,
      OP_MEM_WR,
      OP_REJECT
   } op_e;

   typedef struct packed {
      window_e    window;
      logic       write;
      host_addr_t addr;
      word_t      wdata;
   } host_cmd_t;

   typedef struct packed {
      word_t rdata;
      logic  err;
   } host_rsp_t;

   typedef struct packed {
      op_e         op;
      csr_idx_t    csr;
      word_t       mem_addr;
      region_idx_t region;
      word_t       wdata;
   } dec_op_t;

   typedef struct packed {
      logic  write;
      word_t addr;
      word_t wdata;
   } mem_cmd_t;

   typedef struct packed {
      logic  run;
      logic  dram_valid;
      word_t dram_base;
   } shell_ctrl_t;

endpackage

// ==== hw/bridge_decode.sv ====
module bridge_decode
  (input  logic                         s01_axi_aclk_i
   , input  logic                       rst_i
   , input  logic                       start_i
   , input  zynq_bridge_pkg::host_cmd_t   host_cmd_i
   , input  zynq_bridge_pkg::shell_ctrl_t shell_ctrl_i
   , output logic                       dec_valid_o
   , output zynq_bridge_pkg::dec_op_t     dec_op_o
   );

   import zynq_bridge_pkg::*;

   bp_addr_t bp_addr;
   csr_idx_t csr_idx;
   logic     csr_writable;
   logic     csr_readable;
   logic     accel_blocked;
   dec_op_t  op_d;

   // bit 29 of the host window is inverted and moved up to bit 31, so host 0x0xxx_xxxx
   // lands in accelerator DRAM and 0x2xxx_xxxx below it
   assign bp_addr = {~host_cmd_i.addr[29], 3'b000, host_cmd_i.addr[27:0]};

   assign csr_idx = host_cmd_i.addr[5:2];

   assign csr_writable = (csr_idx == CSR_RUN)
                         || (csr_idx == CSR_DRAM_VALID)
                         || (csr_idx == CSR_DRAM_BASE);

   // the profiler words can be read but never written
   assign csr_readable = csr_writable
                         || ((csr_idx >= CSR_PROFILE0)
                             && (csr_idx < CSR_PROFILE0 + PROFILE_WORDS));

   // no accesses before the host has enabled the accelerator and handed it DRAM,
   // and nothing below the DRAM base since the local device space is not modelled
   assign accel_blocked = !shell_ctrl_i.run
                          || !shell_ctrl_i.dram_valid
                          || (bp_addr < BP_DRAM_BASE);

   always_comb begin
      op_d.csr    = csr_idx;
      op_d.wdata  = host_cmd_i.wdata;
      // flipping the top bit removes the accelerator DRAM base
      op_d.mem_addr = (bp_addr ^ BP_DRAM_BASE) + shell_ctrl_i.dram_base;
      // each profiler bit covers one 8 MB region
      op_d.region = bp_addr[29:23];

      if (host_cmd_i.window == WIN_SHELL) begin
         if (host_cmd_i.write) begin
            op_d.op = csr_writable ? OP_CSR_WR : OP_REJECT;
         end else begin
            op_d.op = csr_readable ? OP_CSR_RD : OP_REJECT;
         end
      end else if (accel_blocked) begin
         op_d.op = OP_REJECT;
      end else begin
         op_d.op = host_cmd_i.write ? OP_MEM_WR : OP_MEM_RD;
      end
   end

   always_ff @(posedge s01_axi_aclk_i) begin
      if (rst_i) begin
         dec_valid_o <= 1'b0;
      end else if (start_i) begin
         dec_valid_o <= 1'b1;
      end
   end

   // the decoded operation stays put until the next command starts
   always_ff @(posedge s01_axi_aclk_i) begin
      if (start_i) begin
         dec_op_o <= op_d;
      end
   end

   assert property (@(posedge s01_axi_aclk_i) disable iff (rst_i)
      $rose(dec_valid_o) |-> $past(start_i));

endmodule

// ==== hw/shell_csr.sv ====
module shell_csr
  (input  logic                          s01_axi_aclk_i
   , input  logic                        rst_i
   , input  logic                        csr_we_i
   , input  zynq_bridge_pkg::csr_idx_t    csr_idx_i
   , input  zynq_bridge_pkg::word_t       csr_wdata_i
   , input  logic                        profile_mark_i
   , input  zynq_bridge_pkg::region_idx_t region_i
   , output zynq_bridge_pkg::shell_ctrl_t shell_ctrl_o
   , output zynq_bridge_pkg::word_t       csr_rdata_o
   , output logic                        accel_run_o
   );

   import zynq_bridge_pkg::*;

   logic     run_q;
   logic     dram_valid_q;
   word_t    dram_base_q;
   profile_t profile_q;
   logic     prof_hit;
   logic [1:0] prof_sel;

   // run is the inverse of the accelerator reset
   always_ff @(posedge s01_axi_aclk_i) begin
      if (rst_i) begin
         run_q        <= 1'b0;
         dram_valid_q <= 1'b0;
         dram_base_q  <= '0;
      end else if (csr_we_i) begin
         case (csr_idx_i)
            CSR_RUN:        run_q        <= csr_wdata_i[0];
            CSR_DRAM_VALID: dram_valid_q <= csr_wdata_i[0];
            CSR_DRAM_BASE:  dram_base_q  <= csr_wdata_i;
            default: ;
         endcase
      end
   end

   // the bitmap is held in reset together with the accelerator,
   // so it only records accesses made while run is set
   always_ff @(posedge s01_axi_aclk_i) begin
      if (rst_i || !run_q) begin
         profile_q <= '0;
      end else if (profile_mark_i) begin
         profile_q[region_i] <= 1'b1;
      end
   end

   assign prof_hit = (csr_idx_i >= CSR_PROFILE0)
                     && (csr_idx_i < CSR_PROFILE0 + PROFILE_WORDS);
   assign prof_sel = 2'(csr_idx_i - CSR_PROFILE0);

   always_comb begin
      csr_rdata_o = '0;
      if (prof_hit) begin
         csr_rdata_o = profile_q[prof_sel*WORD_W +: WORD_W];
      end else begin
         case (csr_idx_i)
            CSR_RUN:        csr_rdata_o = {{(WORD_W-1){1'b0}}, run_q};
            CSR_DRAM_VALID: csr_rdata_o = {{(WORD_W-1){1'b0}}, dram_valid_q};
            CSR_DRAM_BASE:  csr_rdata_o = dram_base_q;
            default:        csr_rdata_o = '0;
         endcase
      end
   end

   assign shell_ctrl_o.run        = run_q;
   assign shell_ctrl_o.dram_valid = dram_valid_q;
   assign shell_ctrl_o.dram_base  = dram_base_q;

   assign accel_run_o = run_q;

endmodule

// ==== hw/mem_execute.sv ====
module mem_execute
  (input  logic                      s01_axi_aclk_i
   , input  logic                    rst_i
   , input  logic                    start_i
   , input  logic                    write_i
   , input  zynq_bridge_pkg::word_t   addr_i
   , input  zynq_bridge_pkg::word_t   wdata_i
   , output logic                    mem_req_o
   , output zynq_bridge_pkg::mem_cmd_t mem_cmd_o
   , input  logic                    mem_ack_i
   , input  zynq_bridge_pkg::word_t   mem_rdata_i
   , output logic                    done_o
   , output zynq_bridge_pkg::word_t   rdata_o
   );

   import zynq_bridge_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      REQ,
      RELEASE,
      DONE
   } state_e;

   state_e   state_q;
   mem_cmd_t cmd_q;
   word_t    rdata_q;

   // four-phase master that raises req, waits for ack, drops req and waits for ack to fall
   always_ff @(posedge s01_axi_aclk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  state_q <= REQ;
               end
            end
            REQ: begin
               if (mem_ack_i) begin
                  state_q <= RELEASE;
               end
            end
            RELEASE: begin
               // the memory may hold ack for as long as it likes
               if (!mem_ack_i) begin
                  state_q <= DONE;
               end
            end
            DONE: begin
               state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge s01_axi_aclk_i) begin
      if (state_q == IDLE && start_i) begin
         cmd_q <= '{write: write_i, addr: addr_i, wdata: wdata_i};
      end
      if (state_q == REQ && mem_ack_i) begin
         rdata_q <= mem_rdata_i;
      end
   end

   assign mem_req_o = (state_q == REQ);
   assign mem_cmd_o = cmd_q;
   assign done_o    = (state_q == DONE);
   assign rdata_o   = rdata_q;

   assert property (@(posedge s01_axi_aclk_i) disable iff (rst_i)
      mem_req_o && $past(mem_req_o) |-> $stable(mem_cmd_o));

endmodule

// ==== hw/bridge_result.sv ====
module bridge_result
  (input  logic                        s01_axi_aclk_i
   , input  logic                      rst_i
   , input  logic                      host_req_i
   , output logic                      host_ack_o
   , output zynq_bridge_pkg::host_rsp_t host_rsp_o
   , output logic                      start_o
   , input  logic                      dec_valid_i
   , input  zynq_bridge_pkg::dec_op_t   dec_op_i
   , input  zynq_bridge_pkg::word_t     csr_rdata_i
   , output logic                      csr_we_o
   , output zynq_bridge_pkg::csr_idx_t  csr_idx_o
   , output zynq_bridge_pkg::word_t     csr_wdata_o
   , output logic                      profile_mark_o
   , output zynq_bridge_pkg::region_idx_t region_o
   , output logic                      mem_start_o
   , output logic                      mem_write_o
   , output zynq_bridge_pkg::word_t     mem_addr_o
   , output zynq_bridge_pkg::word_t     mem_wdata_o
   , input  logic                      mem_done_i
   , input  zynq_bridge_pkg::word_t     mem_rdata_i
   );

   import zynq_bridge_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      DECODE,
      EXEC,
      ACK,
      WAIT_LOW
   } state_e;

   state_e    state_q;
   logic      ack_q;
   logic      csr_we_q;
   logic      mem_start_q;
   host_rsp_t rsp_q;
   logic      is_mem_op;

   assign is_mem_op = (dec_op_i.op == OP_MEM_RD) || (dec_op_i.op == OP_MEM_WR);

   // ack is low in IDLE, so a raised req here is always a fresh command
   assign start_o = (state_q == IDLE) && host_req_i;

   always_ff @(posedge s01_axi_aclk_i) begin
      if (rst_i) begin
         state_q     <= IDLE;
         ack_q       <= 1'b0;
         csr_we_q    <= 1'b0;
         mem_start_q <= 1'b0;
      end else begin
         csr_we_q    <= 1'b0;
         mem_start_q <= 1'b0;
         case (state_q)
            IDLE: begin
               if (host_req_i) begin
                  state_q <= DECODE;
               end
            end
            DECODE: begin
               if (dec_valid_i) begin
                  csr_we_q    <= (dec_op_i.op == OP_CSR_WR);
                  mem_start_q <= is_mem_op;
                  state_q     <= EXEC;
               end
            end
            EXEC: begin
               // memory operations stay here for the whole memory handshake
               if (!is_mem_op || mem_done_i) begin
                  ack_q   <= 1'b1;
                  state_q <= ACK;
               end
            end
            ACK: begin
               if (!host_req_i) begin
                  ack_q   <= 1'b0;
                  state_q <= WAIT_LOW;
               end
            end
            WAIT_LOW: begin
               state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // response is rebuilt every EXEC cycle; the last one before ACK sticks
   always_ff @(posedge s01_axi_aclk_i) begin
      if (state_q == EXEC) begin
         case (dec_op_i.op)
            OP_CSR_RD: rsp_q <= '{rdata: csr_rdata_i, err: 1'b0};
            OP_MEM_RD: rsp_q <= '{rdata: mem_rdata_i, err: 1'b0};
            OP_REJECT: rsp_q <= '{rdata: '0, err: 1'b1};
            default:   rsp_q <= '{rdata: '0, err: 1'b0};
         endcase
      end
   end

   assign host_ack_o = ack_q;
   assign host_rsp_o = rsp_q;

   assign csr_we_o    = csr_we_q;
   assign csr_idx_o   = dec_op_i.csr;
   assign csr_wdata_o = dec_op_i.wdata;

   // every issued memory access is also recorded by the profiler
   assign mem_start_o    = mem_start_q;
   assign profile_mark_o = mem_start_q;
   assign region_o       = dec_op_i.region;
   assign mem_write_o    = (dec_op_i.op == OP_MEM_WR);
   assign mem_addr_o     = dec_op_i.mem_addr;
   assign mem_wdata_o    = dec_op_i.wdata;

   assert property (@(posedge s01_axi_aclk_i) disable iff (rst_i)
      $rose(host_ack_o) |-> $past(host_req_i));

endmodule

// ==== hw/zynq_bridge_top.sv ====
module zynq_bridge_top
  (input  logic                        s01_axi_aclk_i
   , input  logic                      rst_i
   , input  logic                      host_req_i
   , input  zynq_bridge_pkg::host_cmd_t host_cmd_i
   , output logic                      host_ack_o
   , output zynq_bridge_pkg::host_rsp_t host_rsp_o
   , output logic                      mem_req_o
   , output zynq_bridge_pkg::mem_cmd_t  mem_cmd_o
   , input  logic                      mem_ack_i
   , input  zynq_bridge_pkg::word_t     mem_rdata_i
   , output logic                      accel_run_o
   );

   import zynq_bridge_pkg::*;

   logic        start;
   logic        dec_valid;
   dec_op_t     dec_op;
   shell_ctrl_t shell_ctrl;
   logic        csr_we;
   csr_idx_t    csr_idx;
   word_t       csr_wdata;
   word_t       csr_rdata;
   logic        profile_mark;
   region_idx_t region;
   logic        mem_start;
   logic        mem_write;
   word_t       mem_addr;
   word_t       mem_wdata;
   logic        mem_done;
   word_t       exe_rdata;

   bridge_result result
     (.s01_axi_aclk_i  (s01_axi_aclk_i)
      ,.rst_i          (rst_i)
      ,.host_req_i     (host_req_i)
      ,.host_ack_o     (host_ack_o)
      ,.host_rsp_o     (host_rsp_o)
      ,.start_o        (start)
      ,.dec_valid_i    (dec_valid)
      ,.dec_op_i       (dec_op)
      ,.csr_rdata_i    (csr_rdata)
      ,.csr_we_o       (csr_we)
      ,.csr_idx_o      (csr_idx)
      ,.csr_wdata_o    (csr_wdata)
      ,.profile_mark_o (profile_mark)
      ,.region_o       (region)
      ,.mem_start_o    (mem_start)
      ,.mem_write_o    (mem_write)
      ,.mem_addr_o     (mem_addr)
      ,.mem_wdata_o    (mem_wdata)
      ,.mem_done_i     (mem_done)
      ,.mem_rdata_i    (exe_rdata)
      );

   bridge_decode decode
     (.s01_axi_aclk_i (s01_axi_aclk_i)
      ,.rst_i         (rst_i)
      ,.start_i       (start)
      ,.host_cmd_i    (host_cmd_i)
      ,.shell_ctrl_i  (shell_ctrl)
      ,.dec_valid_o   (dec_valid)
      ,.dec_op_o      (dec_op)
      );

   shell_csr csr
     (.s01_axi_aclk_i  (s01_axi_aclk_i)
      ,.rst_i          (rst_i)
      ,.csr_we_i       (csr_we)
      ,.csr_idx_i      (csr_idx)
      ,.csr_wdata_i    (csr_wdata)
      ,.profile_mark_i (profile_mark)
      ,.region_i       (region)
      ,.shell_ctrl_o   (shell_ctrl)
      ,.csr_rdata_o    (csr_rdata)
      ,.accel_run_o    (accel_run_o)
      );

   mem_execute exe
     (.s01_axi_aclk_i (s01_axi_aclk_i)
      ,.rst_i         (rst_i)
      ,.start_i       (mem_start)
      ,.write_i       (mem_write)
      ,.addr_i        (mem_addr)
      ,.wdata_i       (mem_wdata)
      ,.mem_req_o     (mem_req_o)
      ,.mem_cmd_o     (mem_cmd_o)
      ,.mem_ack_i     (mem_ack_i)
      ,.mem_rdata_i   (mem_rdata_i)
      ,.done_o        (mem_done)
      ,.rdata_o       (exe_rdata)
      );

endmodule

// ==== dv/tb_dram_model.sv ====
module tb_dram_model
  (input  logic                        clk_i
   , input  logic                      rst_i
   , input  logic                      mem_req_i
   , input  zynq_bridge_pkg::mem_cmd_t  mem_cmd_i
   , output logic                      mem_ack_o
   , output zynq_bridge_pkg::word_t     mem_rdata_o
   , output int unsigned               req_count_o
   , output zynq_bridge_pkg::word_t     last_addr_o
   );

   import zynq_bridge_pkg::*;

   localparam word_t       FILL_PATTERN = 32'h5A5A_5A5A;
   localparam int unsigned MAX_DELAY    = 5;

   word_t       storage [word_t];
   int unsigned wait_left;
   logic        pending;

   task automatic serve_request();
      word_t addr;
      addr        = mem_cmd_i.addr;
      last_addr_o = addr;
      req_count_o = req_count_o + 1;
      if (mem_cmd_i.write) begin
         storage[addr] = mem_cmd_i.wdata;
         mem_rdata_o   = '0;
      end else if (storage.exists(addr)) begin
         mem_rdata_o = storage[addr];
      end else begin
         // words never written read back as a pattern tied to their address
         mem_rdata_o = addr ^ FILL_PATTERN;
      end
   endtask

   // one step of the four-phase slave is taken on each falling edge
   task automatic step_handshake();
      if (rst_i) begin
         mem_ack_o = 1'b0;
         pending   = 1'b0;
      end else if (mem_ack_o) begin
         if (!mem_req_i) begin
            mem_ack_o = 1'b0;
         end
      end else if (mem_req_i) begin
         if (!pending) begin
            pending   = 1'b1;
            wait_left = $urandom % (MAX_DELAY + 1);
         end
         if (wait_left == 0) begin
            serve_request();
            mem_ack_o = 1'b1;
            pending   = 1'b0;
         end else begin
            wait_left = wait_left - 1;
         end
      end
   endtask

   initial begin
      mem_ack_o   = 1'b0;
      mem_rdata_o = '0;
      req_count_o = 0;
      last_addr_o = '0;
      wait_left   = 0;
      pending     = 1'b0;
      forever begin
         @(negedge clk_i);
         step_handshake();
      end
   end

endmodule

// ==== dv/tb_zynq_bridge.sv ====
module tb_zynq_bridge;

   import zynq_bridge_pkg::*;

   localparam int unsigned CLK_PERIOD    = 40;
   localparam int unsigned RESET_CYCLES  = 3;
   localparam int unsigned RAND_SEED     = 25;
   localparam int unsigned ACK_TIMEOUT   = 200;
   localparam int unsigned RAND_ACCESSES = 30;
   localparam word_t       FILL_PATTERN  = 32'h5A5A_5A5A;
   localparam word_t       TEST_BASE     = 32'h1000_0000;

   typedef enum logic {
      MEM_NONE,
      MEM_AT
   } mem_chk_e;

   typedef struct {
      string     name;
      host_cmd_t cmd;
      logic      exp_err;
      logic      chk_rdata;
      word_t     exp_rdata;
      mem_chk_e  mem_chk;
      word_t     exp_mem;
   } step_t;

   logic        aclk;
   logic        rst;
   logic        host_req;
   host_cmd_t   host_cmd;
   logic        host_ack;
   host_rsp_t   host_rsp;
   logic        mem_req;
   mem_cmd_t    mem_cmd;
   logic        mem_ack;
   word_t       mem_rdata;
   logic        accel_run;
   int unsigned req_count;
   word_t       last_addr;

   step_t       steps[$];
   profile_t    exp_profile;
   word_t       ref_mem [word_t];
   host_addr_t  pool [8];
   logic        exp_run;
   int unsigned errors;
   int unsigned tests_run;
   int unsigned tests_failed;
   logic        hung;

   zynq_bridge_top uut
     (.s01_axi_aclk_i (aclk)
      ,.rst_i         (rst)
      ,.host_req_i    (host_req)
      ,.host_cmd_i    (host_cmd)
      ,.host_ack_o    (host_ack)
      ,.host_rsp_o    (host_rsp)
      ,.mem_req_o     (mem_req)
      ,.mem_cmd_o     (mem_cmd)
      ,.mem_ack_i     (mem_ack)
      ,.mem_rdata_i   (mem_rdata)
      ,.accel_run_o   (accel_run)
      );

   tb_dram_model dram
     (.clk_i        (aclk)
      ,.rst_i       (rst)
      ,.mem_req_i   (mem_req)
      ,.mem_cmd_i   (mem_cmd)
      ,.mem_ack_o   (mem_ack)
      ,.mem_rdata_o (mem_rdata)
      ,.req_count_o (req_count)
      ,.last_addr_o (last_addr)
      );

   initial aclk = 1'b0;
   always #(CLK_PERIOD / 2) aclk = ~aclk;

   // host address with bits 31 to 28 cleared and moved up by the DRAM base
   function automatic word_t dram_addr(host_addr_t a, word_t base);
      return ({2'b00, a} & 32'h0FFF_FFFF) + base;
   endfunction

   task automatic add_step(input string name, input window_e win, input logic write,
                           input host_addr_t addr, input word_t wdata, input logic exp_err,
                           input word_t exp_rdata, input mem_chk_e mem_chk,
                           input word_t exp_mem);
      step_t s;
      s.name       = name;
      s.cmd.window = win;
      s.cmd.write  = write;
      s.cmd.addr   = addr;
      s.cmd.wdata  = wdata;
      s.exp_err    = exp_err;
      // writes only carry read data when they are rejected
      s.chk_rdata  = !write || exp_err;
      s.exp_rdata  = exp_rdata;
      s.mem_chk    = mem_chk;
      s.exp_mem    = exp_mem;
      steps.push_back(s);
   endtask

   task automatic add_csr(input string name, input logic write, input int unsigned idx,
                          input word_t wdata, input logic exp_err, input word_t exp_rdata);
      add_step(name, WIN_SHELL, write, host_addr_t'(idx << 2), wdata, exp_err, exp_rdata,
               MEM_NONE, '0);
   endtask

   task automatic add_mem(input string name, input logic write, input host_addr_t addr,
                          input word_t wdata, input word_t exp_rdata);
      add_step(name, WIN_ACCEL, write, addr, wdata, 1'b0, exp_rdata, MEM_AT,
               dram_addr(addr, TEST_BASE));
      exp_profile[addr[29:23]] = 1'b1;
   endtask

   task automatic add_reject(input string name, input logic write, input host_addr_t addr);
      add_step(name, WIN_ACCEL, write, addr, 32'h1234_5678, 1'b1, '0, MEM_NONE, '0);
   endtask

   task automatic add_profile_reads(input string name);
      for (int k = 0; k < PROFILE_WORDS; k++) begin
         add_csr($sformatf("%s word %0d", name, k), 1'b0, CSR_PROFILE0 + k, '0, 1'b0,
                 exp_profile[k*32 +: 32]);
      end
   endtask

   task automatic build_table();
      exp_profile = '0;
      add_csr("reset run", 1'b0, 0, '0, 1'b0, '0);
      add_csr("reset dram valid", 1'b0, 1, '0, 1'b0, '0);
      add_csr("reset dram base", 1'b0, 2, '0, 1'b0, '0);
      add_csr("write dram base", 1'b1, 2, TEST_BASE, 1'b0, '0);
      add_csr("read dram base", 1'b0, 2, '0, 1'b0, TEST_BASE);
      add_reject("accel read, run 0 valid 0", 1'b0, 30'h0000_1000);
      add_csr("write dram valid 1", 1'b1, 1, 32'd1, 1'b0, '0);
      add_csr("read dram valid", 1'b0, 1, '0, 1'b0, 32'd1);
      add_reject("accel write, run 0", 1'b1, 30'h0000_2000);
      add_csr("write dram valid 0", 1'b1, 1, '0, 1'b0, '0);
      add_csr("write run 1", 1'b1, 0, 32'd1, 1'b0, '0);
      add_csr("read run", 1'b0, 0, '0, 1'b0, 32'd1);
      add_reject("accel read, dram valid 0", 1'b0, 30'h0000_3000);
      add_csr("write dram valid 1 again", 1'b1, 1, 32'd1, 1'b0, '0);
      add_reject("accel read, bit 29 set", 1'b0, 30'h2000_1000);
      add_reject("accel write, bit 29 set", 1'b1, 30'h2A00_0000);
      add_mem("accel write A1", 1'b1, 30'h0012_3450, 32'hCAFE_0001, '0);
      add_mem("accel read A1", 1'b0, 30'h0012_3450, '0, 32'hCAFE_0001);
      add_mem("accel first read A2", 1'b0, 30'h0345_6780, '0,
              dram_addr(30'h0345_6780, TEST_BASE) ^ FILL_PATTERN);
      add_mem("accel write A3", 1'b1, 30'h07F0_0000, 32'h0BAD_F00D, '0);
      add_mem("accel first read A4", 1'b0, 30'h0400_0000, '0,
              dram_addr(30'h0400_0000, TEST_BASE) ^ FILL_PATTERN);
      add_profile_reads("profile after accesses");
      // the profiler words are read-only, so the write must bounce
      add_csr("write profile word 0", 1'b1, 4, 32'hFFFF_FFFF, 1'b1, '0);
      add_csr("reread profile word 0", 1'b0, 4, '0, 1'b0, exp_profile[31:0]);
      add_csr("read unmapped 9", 1'b0, 9, '0, 1'b1, '0);
      add_csr("write unmapped 9", 1'b1, 9, 32'h0000_00A5, 1'b1, '0);
      add_csr("reread unmapped 9", 1'b0, 9, '0, 1'b1, '0);
      add_csr("write run 0", 1'b1, 0, '0, 1'b0, '0);
      exp_profile = '0;
      add_profile_reads("profile after run 0");
      add_csr("write run 1 for random", 1'b1, 0, 32'd1, 1'b0, '0);
   endtask

   // four-phase host master that changes its inputs on the falling edge
   task automatic host_xfer(input host_cmd_t cmd, output host_rsp_t rsp);
      int unsigned n;
      rsp = '0;
      @(negedge aclk);
      host_cmd = cmd;
      host_req = 1'b1;
      n = 0;
      while (!host_ack && n < ACK_TIMEOUT) begin
         @(negedge aclk);
         n++;
      end
      if (!host_ack) begin
         $display("timeout at %0t: host ack did not rise within %0d cycles", $time, ACK_TIMEOUT);
         hung = 1'b1;
      end else begin
         rsp      = host_rsp;
         host_req = 1'b0;
         n = 0;
         while (host_ack && n < ACK_TIMEOUT) begin
            @(negedge aclk);
            n++;
         end
         if (host_ack) begin
            $display("timeout at %0t: host ack stayed high after req fell", $time);
            hung = 1'b1;
         end
      end
   endtask

   task automatic check_rsp(input string name, input host_rsp_t rsp, input logic exp_err,
                            input logic chk_rdata, input word_t exp_rdata);
      assert (rsp.err == exp_err) else begin
         $display("Error at %0t: %s returned err %0b, expected %0b",
                  $time, name, rsp.err, exp_err);
         errors++;
      end
      if (chk_rdata) begin
         assert (rsp.rdata == exp_rdata) else begin
            $display("Error at %0t: %s returned data %h, expected %h",
                     $time, name, rsp.rdata, exp_rdata);
            errors++;
         end
      end
   endtask

   task automatic check_mem(input string name, input int unsigned count_before,
                            input mem_chk_e mem_chk, input word_t exp_mem);
      if (mem_chk == MEM_NONE) begin
         assert (req_count == count_before) else begin
            $display("Error at %0t: %s reached memory %0d times, expected none",
                     $time, name, req_count - count_before);
            errors++;
         end
      end else begin
         assert (req_count == count_before + 1 && last_addr == exp_mem) else begin
            $display("Error at %0t: %s made %0d requests, last at %h, expected one at %h",
                     $time, name, req_count - count_before, last_addr, exp_mem);
            errors++;
         end
      end
   endtask

   task automatic check_run(input string name, input host_cmd_t cmd, input logic exp_err);
      // an accepted write to the run register sets what accel_run_o must show
      if (cmd.window == WIN_SHELL && cmd.write && !exp_err && cmd.addr[5:2] == CSR_RUN) begin
         exp_run = cmd.wdata[0];
      end
      assert (accel_run == exp_run) else begin
         $display("Error at %0t: %s left accel run %0b, expected %0b",
                  $time, name, accel_run, exp_run);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int unsigned errors_before);
      tests_run++;
      if (errors == errors_before && !hung) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAILED", tests_run, name);
      end
   endtask

   task automatic check_reset_outputs();
      int unsigned errors_before;
      errors_before = errors;
      assert (!accel_run && !host_ack && !mem_req) else begin
         $display("Error at %0t: after reset run %0b ack %0b mem req %0b, expected all low",
                  $time, accel_run, host_ack, mem_req);
         errors++;
      end
      report_test("outputs after reset", errors_before);
   endtask

   task automatic run_step(input int i);
      step_t       s;
      host_rsp_t   rsp;
      int unsigned count_before;
      int unsigned errors_before;
      s             = steps[i];
      count_before  = req_count;
      errors_before = errors;
      host_xfer(s.cmd, rsp);
      if (!hung) begin
         check_rsp(s.name, rsp, s.exp_err, s.chk_rdata, s.exp_rdata);
         check_mem(s.name, count_before, s.mem_chk, s.exp_mem);
         check_run(s.name, s.cmd, s.exp_err);
      end
      report_test(s.name, errors_before);
   endtask

   task automatic random_accesses();
      host_cmd_t   cmd;
      host_rsp_t   rsp;
      word_t       dram;
      word_t       exp;
      int unsigned count_before;
      int unsigned errors_before;
      errors_before = errors;
      // a small address pool with bit 27 set, so reads often hit earlier writes
      for (int k = 0; k < 8; k++) begin
         pool[k] = host_addr_t'(32'h0800_0000 | ($urandom & 32'h07FF_FFFC));
      end
      for (int n = 0; n < RAND_ACCESSES; n++) begin
         cmd.window = WIN_ACCEL;
         cmd.write  = 1'($urandom);
         cmd.addr   = pool[3'($urandom)];
         cmd.wdata  = $urandom;
         dram       = dram_addr(cmd.addr, TEST_BASE);
         exp        = ref_mem.exists(dram) ? ref_mem[dram] : (dram ^ FILL_PATTERN);
         count_before = req_count;
         host_xfer(cmd, rsp);
         if (hung) begin
            break;
         end
         check_rsp($sformatf("random access %0d", n), rsp, 1'b0, !cmd.write, exp);
         check_mem($sformatf("random access %0d", n), count_before, MEM_AT, dram);
         if (cmd.write) begin
            ref_mem[dram] = cmd.wdata;
         end
      end
      report_test("random accesses", errors_before);
   endtask

   initial begin
      void'($urandom(RAND_SEED));
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      hung         = 1'b0;
      exp_run      = 1'b0;
      rst          = 1'b1;
      host_req     = 1'b0;
      host_cmd     = '0;
      build_table();
      repeat (RESET_CYCLES) @(posedge aclk);
      @(negedge aclk);
      rst = 1'b0;
      check_reset_outputs();
      foreach (steps[i]) begin
         if (!hung) begin
            run_step(i);
         end
      end
      if (!hung) begin
         random_accesses();
      end
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0 && !hung) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== zynq_bridge.f ====
hw/zynq_bridge_pkg.sv
hw/bridge_decode.sv
hw/shell_csr.sv
hw/mem_execute.sv
hw/bridge_result.sv
hw/zynq_bridge_top.sv
dv/tb_dram_model.sv
dv/tb_zynq_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the bridge testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
      --top-module tb_zynq_bridge -f zynq_bridge.f; then
   echo "verilator build failed"
   exit 1
fi

sim_out="$(./obj_dir/Vtb_zynq_bridge)"
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
